// File: hdl/ruche_pkg.sv
`default_nettype none

package ruche_pkg;

  localparam int x_cord_width = 4;   // x coordinate bits.
  localparam int y_cord_width = 3;   // y coordinate bits.
  localparam int addr_width = 16;    // request address bits.
  localparam int data_width = 32;    // data word bits.
  localparam int link_width = addr_width + data_width
                            + 2 * y_cord_width + 2 * x_cord_width;  // 62, sum of fwd fields.
  localparam int rev_pad_width = link_width - data_width - y_cord_width - x_cord_width;
  localparam int errant_count_width = 8;  // saturating errant counter.

  // request packet, top field first.
  typedef struct packed {
    logic [addr_width-1:0]   addr;
    logic [data_width-1:0]   data;
    logic [y_cord_width-1:0] src_y;
    logic [x_cord_width-1:0] src_x;
    logic [y_cord_width-1:0] dest_y;
    logic [x_cord_width-1:0] dest_x;
  } fwd_packet_t;

  // return packet, padded out to the request width.
  typedef struct packed {
    logic [data_width-1:0]    data;
    logic [rev_pad_width-1:0] pad;   // unused upper bits.
    logic [y_cord_width-1:0]  dest_y;
    logic [x_cord_width-1:0]  dest_x;
  } rev_packet_t;

  // one link word, read as a request on the fwd lane and as a return on the rev lane.
  typedef union packed {
    fwd_packet_t fwd;
    rev_packet_t rev;
  } link_data_t;

  // polarity of signals as they arrive at the edge.
  function automatic bit edge_invert_in(input int factor, input int stages, input bit west);
    bit stage_odd;
    stage_odd = (stages % 2) != 0;
    if (stages == 0) return 1'b0;        // no repeaters, plain polarity.
    if ((factor % 2) == 0) return stage_odd;
    return west ? stage_odd : !stage_odd;  // odd factor depends on the side.
  endfunction

  // polarity the edge must drive, the same rule seen from the other side.
  function automatic bit edge_invert_out(input int factor, input int stages, input bit west);
    return edge_invert_in(factor, stages, !west);
  endfunction

endpackage

`default_nettype wire

// File: hdl/ruche_link_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ruche_link_stage #(
  parameter logic [1:0] reset_invert_p = 2'b00  // idle polarity, [0] toward edge, [1] back.
) (
  input  wire                            clk_i,
  input  wire                            reset_i,
  input  wire                            in_fwd_v,
  input  wire  [ruche_pkg::link_width-1:0] in_fwd_data,
  input  wire                            in_rev_v,
  input  wire  [ruche_pkg::link_width-1:0] in_rev_data,
  input  wire                            in_ready_back,
  output logic                           out_fwd_v,
  output logic [ruche_pkg::link_width-1:0] out_fwd_data,
  output logic                           out_rev_v,
  output logic [ruche_pkg::link_width-1:0] out_rev_data,
  output logic                           out_ready_back,
  input  wire                            back_in_fwd_v,
  input  wire  [ruche_pkg::link_width-1:0] back_in_fwd_data,
  input  wire                            back_in_rev_v,
  input  wire  [ruche_pkg::link_width-1:0] back_in_rev_data,
  input  wire                            back_in_ready,
  output logic                           back_out_fwd_v,
  output logic [ruche_pkg::link_width-1:0] back_out_fwd_data,
  output logic                           back_out_rev_v,
  output logic [ruche_pkg::link_width-1:0] back_out_rev_data,
  output logic                           back_out_ready
);
  import ruche_pkg::*;

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      out_fwd_v         <= reset_invert_p[0];  // load the value that decodes as idle.
      out_fwd_data      <= {link_width{reset_invert_p[0]}};
      out_rev_v         <= reset_invert_p[0];
      out_rev_data      <= {link_width{reset_invert_p[0]}};
      out_ready_back    <= reset_invert_p[0];
      back_out_fwd_v    <= reset_invert_p[1];
      back_out_fwd_data <= {link_width{reset_invert_p[1]}};
      back_out_rev_v    <= reset_invert_p[1];
      back_out_rev_data <= {link_width{reset_invert_p[1]}};
      back_out_ready    <= reset_invert_p[1];
    end else begin
      out_fwd_v         <= ~in_fwd_v;          // inverting repeater, no buffer needed.
      out_fwd_data      <= ~in_fwd_data;
      out_rev_v         <= ~in_rev_v;
      out_rev_data      <= ~in_rev_data;
      out_ready_back    <= ~in_ready_back;
      back_out_fwd_v    <= ~back_in_fwd_v;
      back_out_fwd_data <= ~back_in_fwd_data;
      back_out_rev_v    <= ~back_in_rev_v;
      back_out_rev_data <= ~back_in_rev_data;
      back_out_ready    <= ~back_in_ready;
    end
  end

  // a tile that injects an unknown valid would poison every stage behind it.
  a_fwd_v_known: assert property (@(posedge clk_i) disable iff (!reset_i)
    !$isunknown(out_fwd_v ^ reset_invert_p[0]))
    else $error("ruche stage fwd valid is unknown");

endmodule

`default_nettype wire

// File: hdl/ruche_link_chain.sv
`timescale 1ns/100ps
`default_nettype none

module ruche_link_chain #(
  parameter int ruche_factor_p  = 3,
  parameter int ruche_stage_p   = 2,
  parameter bit west_not_east_p = 1'b1
) (
  input  wire                              clk_i,
  input  wire                              reset_i,
  input  wire                              tile_fwd_v,
  input  wire  [ruche_pkg::link_width-1:0] tile_fwd_data,
  input  wire                              tile_rev_v,
  input  wire  [ruche_pkg::link_width-1:0] tile_rev_data,
  input  wire                              tile_ready_back,
  output logic                             edge_fwd_v,
  output logic [ruche_pkg::link_width-1:0] edge_fwd_data,
  output logic                             edge_rev_v,
  output logic [ruche_pkg::link_width-1:0] edge_rev_data,
  output logic                             edge_ready_back,
  input  wire                              edge_back_fwd_v,
  input  wire  [ruche_pkg::link_width-1:0] edge_back_fwd_data,
  input  wire                              edge_back_rev_v,
  input  wire  [ruche_pkg::link_width-1:0] edge_back_rev_data,
  input  wire                              edge_back_ready,
  output logic                             tile_back_fwd_v,
  output logic [ruche_pkg::link_width-1:0] tile_back_fwd_data,
  output logic                             tile_back_rev_v,
  output logic [ruche_pkg::link_width-1:0] tile_back_rev_data,
  output logic                             tile_back_ready
);
  import ruche_pkg::*;

  localparam bit inv_in_lp  = edge_invert_in(ruche_factor_p, ruche_stage_p, west_not_east_p);
  localparam bit inv_out_lp = edge_invert_out(ruche_factor_p, ruche_stage_p, west_not_east_p);

  logic [ruche_stage_p:0]                 fwd_v_w;       // index 0 is the tile side.
  logic [ruche_stage_p:0][link_width-1:0] fwd_data_w;
  logic [ruche_stage_p:0]                 rev_v_w;
  logic [ruche_stage_p:0][link_width-1:0] rev_data_w;
  logic [ruche_stage_p:0]                 ready_w;
  logic [ruche_stage_p:0]                 back_fwd_v_w;  // index ruche_stage_p is the edge.
  logic [ruche_stage_p:0][link_width-1:0] back_fwd_data_w;
  logic [ruche_stage_p:0]                 back_rev_v_w;
  logic [ruche_stage_p:0][link_width-1:0] back_rev_data_w;
  logic [ruche_stage_p:0]                 back_ready_w;

  if (ruche_stage_p < 1 || ruche_stage_p > 4) begin : g_bad_stage
    $error("ruche_stage_p must be 1 to 4");
  end

  assign fwd_v_w[0]    = tile_fwd_v;
  assign fwd_data_w[0] = tile_fwd_data;
  assign rev_v_w[0]    = tile_rev_v;
  assign rev_data_w[0] = tile_rev_data;
  assign ready_w[0]    = tile_ready_back;
  assign edge_fwd_v      = fwd_v_w[ruche_stage_p];
  assign edge_fwd_data   = fwd_data_w[ruche_stage_p];
  assign edge_rev_v      = rev_v_w[ruche_stage_p];
  assign edge_rev_data   = rev_data_w[ruche_stage_p];
  assign edge_ready_back = ready_w[ruche_stage_p];

  assign back_fwd_v_w[ruche_stage_p]    = edge_back_fwd_v;
  assign back_fwd_data_w[ruche_stage_p] = edge_back_fwd_data;
  assign back_rev_v_w[ruche_stage_p]    = edge_back_rev_v;
  assign back_rev_data_w[ruche_stage_p] = edge_back_rev_data;
  assign back_ready_w[ruche_stage_p]    = edge_back_ready;
  assign tile_back_fwd_v    = back_fwd_v_w[0];
  assign tile_back_fwd_data = back_fwd_data_w[0];
  assign tile_back_rev_v    = back_rev_v_w[0];
  assign tile_back_rev_data = back_rev_data_w[0];
  assign tile_back_ready    = back_ready_w[0];

  for (genvar i = 0; i < ruche_stage_p; i++) begin : g_stage
    // idle polarity counts the inversions still ahead of each output.
    localparam bit fwd_inv_lp  = inv_in_lp ^ (((ruche_stage_p - 1 - i) % 2) != 0);
    localparam bit back_inv_lp = inv_out_lp ^ (((ruche_stage_p - i) % 2) != 0);

    ruche_link_stage #(.reset_invert_p({back_inv_lp, fwd_inv_lp})) u_stage (
      .clk_i             (clk_i),
      .reset_i           (reset_i),
      .in_fwd_v          (fwd_v_w[i]),
      .in_fwd_data       (fwd_data_w[i]),
      .in_rev_v          (rev_v_w[i]),
      .in_rev_data       (rev_data_w[i]),
      .in_ready_back     (ready_w[i]),
      .out_fwd_v         (fwd_v_w[i+1]),
      .out_fwd_data      (fwd_data_w[i+1]),
      .out_rev_v         (rev_v_w[i+1]),
      .out_rev_data      (rev_data_w[i+1]),
      .out_ready_back    (ready_w[i+1]),
      .back_in_fwd_v     (back_fwd_v_w[i+1]),
      .back_in_fwd_data  (back_fwd_data_w[i+1]),
      .back_in_rev_v     (back_rev_v_w[i+1]),
      .back_in_rev_data  (back_rev_data_w[i+1]),
      .back_in_ready     (back_ready_w[i+1]),
      .back_out_fwd_v    (back_fwd_v_w[i]),
      .back_out_fwd_data (back_fwd_data_w[i]),
      .back_out_rev_v    (back_rev_v_w[i]),
      .back_out_rev_data (back_rev_data_w[i]),
      .back_out_ready    (back_ready_w[i])
    );
  end

endmodule

`default_nettype wire

// File: hdl/ruche_tile_port.sv
`timescale 1ns/100ps
`default_nettype none

module ruche_tile_port #(
  parameter int ruche_factor_p  = 3,
  parameter int ruche_stage_p   = 2,
  parameter bit west_not_east_p = 1'b1
) (
  input  wire                              fwd_v,
  input  wire  ruche_pkg::link_data_t      fwd_data,
  input  wire                              rev_v,
  input  wire  ruche_pkg::link_data_t      rev_data,
  output logic                             fwd_ready,
  output logic                             rev_ret_v,
  output ruche_pkg::link_data_t            rev_ret_data,
  output logic                             link_fwd_v,
  output logic [ruche_pkg::link_width-1:0] link_fwd_data,
  output logic                             link_rev_v,
  output logic [ruche_pkg::link_width-1:0] link_rev_data,
  output logic                             link_ready_back,
  input  wire                              link_back_fwd_v,
  input  wire  [ruche_pkg::link_width-1:0] link_back_fwd_data,
  input  wire                              link_back_rev_v,
  input  wire  [ruche_pkg::link_width-1:0] link_back_rev_data,
  input  wire                              link_back_ready
);
  import ruche_pkg::*;

  localparam bit stage_odd_lp = (ruche_stage_p % 2) != 0;
  // stage zero polarity, so the edge sees edge_invert_in after the chain.
  localparam bit tx_inv_lp =
    edge_invert_in(ruche_factor_p, ruche_stage_p, west_not_east_p) ^ stage_odd_lp;
  localparam bit rx_inv_lp =
    edge_invert_out(ruche_factor_p, ruche_stage_p, west_not_east_p) ^ stage_odd_lp;
  localparam logic [link_width-1:0] tx_mask_lp = {link_width{tx_inv_lp}};
  localparam logic [link_width-1:0] rx_mask_lp = {link_width{rx_inv_lp}};

  logic                  back_fwd_v;     // plain polarity returns.
  logic [link_width-1:0] back_fwd_data;
  logic                  back_rev_v;
  logic [link_width-1:0] back_rev_data;

  assign link_fwd_v      = fwd_v ^ tx_inv_lp;
  assign link_fwd_data   = fwd_data ^ tx_mask_lp;
  assign link_rev_v      = rev_v ^ tx_inv_lp;
  assign link_rev_data   = rev_data ^ tx_mask_lp;
  assign link_ready_back = ~tx_inv_lp;  // tile always takes returns.

  assign back_fwd_v    = link_back_fwd_v ^ rx_inv_lp;
  assign back_fwd_data = link_back_fwd_data ^ rx_mask_lp;
  assign back_rev_v    = link_back_rev_v ^ rx_inv_lp;
  assign back_rev_data = link_back_rev_data ^ rx_mask_lp;
  assign fwd_ready     = link_back_ready ^ rx_inv_lp;

  // both returning lanes land in the one rev stream, fwd first.
  assign rev_ret_v    = back_fwd_v | back_rev_v;
  assign rev_ret_data = back_fwd_v ? back_fwd_data : back_rev_data;

endmodule

`default_nettype wire

// File: hdl/ruche_edge_tieoff.sv
`timescale 1ns/100ps
`default_nettype none

module ruche_edge_tieoff #(
  parameter int ruche_factor_p  = 3,
  parameter int ruche_stage_p   = 2,
  parameter bit west_not_east_p = 1'b1
) (
  input  wire                                      clk_i,
  input  wire                                      reset_i,
  input  wire                                      edge_fwd_v,
  input  wire  [ruche_pkg::link_width-1:0]         edge_fwd_data,
  input  wire                                      edge_rev_v,
  input  wire  [ruche_pkg::link_width-1:0]         edge_rev_data,
  input  wire                                      edge_ready_back,
  output logic                                     tie_fwd_v,
  output logic [ruche_pkg::link_width-1:0]         tie_fwd_data,
  output logic                                     tie_rev_v,
  output logic [ruche_pkg::link_width-1:0]         tie_rev_data,
  output logic                                     tie_ready,
  output logic                                     errant_fwd,
  output logic                                     errant_rev,
  output logic [ruche_pkg::errant_count_width-1:0] errant_count,
  output logic [ruche_pkg::x_cord_width-1:0]       last_src_x,
  output logic [ruche_pkg::y_cord_width-1:0]       last_dest_y,
  output logic [ruche_pkg::x_cord_width-1:0]       last_dest_x
);
  import ruche_pkg::*;

  localparam bit inv_in_lp  = edge_invert_in(ruche_factor_p, ruche_stage_p, west_not_east_p);
  localparam bit inv_out_lp = edge_invert_out(ruche_factor_p, ruche_stage_p, west_not_east_p);
  localparam logic [link_width-1:0] in_mask_lp = {link_width{inv_in_lp}};
  localparam logic [errant_count_width-1:0] count_max_lp = '1;

  logic                        fwd_hit;     // decoded valids at the edge.
  logic                        rev_hit;
  link_data_t                  fwd_word;    // read as a request.
  link_data_t                  rev_word;    // read as a return.
  logic [errant_count_width:0] count_sum;   // one spare bit for saturation.

  // constant that decodes as idle, not ready, at the tile.
  assign tie_fwd_v    = inv_out_lp;
  assign tie_fwd_data = {link_width{inv_out_lp}};
  assign tie_rev_v    = inv_out_lp;
  assign tie_rev_data = {link_width{inv_out_lp}};
  assign tie_ready    = inv_out_lp;

  assign fwd_hit    = edge_fwd_v ^ inv_in_lp;
  assign rev_hit    = edge_rev_v ^ inv_in_lp;
  assign fwd_word   = edge_fwd_data ^ in_mask_lp;
  assign rev_word   = edge_rev_data ^ in_mask_lp;

  // both lanes in one cycle add two.
  assign count_sum = {1'b0, errant_count}
                   + (errant_count_width + 1)'(fwd_hit)
                   + (errant_count_width + 1)'(rev_hit);

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      errant_fwd   <= 1'b0;
      errant_rev   <= 1'b0;
      errant_count <= '0;
      last_src_x   <= '0;
      last_dest_y  <= '0;
      last_dest_x  <= '0;
    end else begin
      errant_fwd   <= fwd_hit;  // one pulse per packet.
      errant_rev   <= rev_hit;
      errant_count <= count_sum[errant_count_width] ? count_max_lp
                                                    : count_sum[errant_count_width-1:0];
      if (fwd_hit) begin          // fwd wins the capture.
        last_src_x  <= fwd_word.fwd.src_x;
        last_dest_y <= fwd_word.fwd.dest_y;
        last_dest_x <= fwd_word.fwd.dest_x;
      end else if (rev_hit) begin
        last_src_x  <= '0;        // return carries no source.
        last_dest_y <= rev_word.rev.dest_y;
        last_dest_x <= rev_word.rev.dest_x;
      end
    end
  end

  a_count_monotonic: assert property (@(posedge clk_i) disable iff (!reset_i)
    errant_count >= $past(errant_count))
    else $error("errant count went down");

endmodule

`default_nettype wire

// File: hdl/ruche_x_edge_top.sv
`timescale 1ns/100ps
`default_nettype none

module ruche_x_edge_top #(
  parameter int ruche_factor_p  = 3,
  parameter int ruche_stage_p   = 2,
  parameter bit west_not_east_p = 1'b1
) (
  input  wire                                      clk_i,
  input  wire                                      reset_i,
  input  wire                                      fwd_v,
  input  wire  ruche_pkg::link_data_t              fwd_data,
  input  wire                                      rev_v,
  input  wire  ruche_pkg::link_data_t              rev_data,
  output logic                                     fwd_ready,
  output logic                                     rev_ret_v,
  output ruche_pkg::link_data_t                    rev_ret_data,
  output logic                                     errant_fwd,
  output logic                                     errant_rev,
  output logic [ruche_pkg::errant_count_width-1:0] errant_count,
  output logic [ruche_pkg::x_cord_width-1:0]       last_src_x,
  output logic [ruche_pkg::y_cord_width-1:0]       last_dest_y,
  output logic [ruche_pkg::x_cord_width-1:0]       last_dest_x
);
  import ruche_pkg::*;

  logic                  link_fwd_v;         // tile port into the chain.
  logic [link_width-1:0] link_fwd_data;
  logic                  link_rev_v;
  logic [link_width-1:0] link_rev_data;
  logic                  link_ready_back;
  logic                  link_back_fwd_v;    // chain back into the tile port.
  logic [link_width-1:0] link_back_fwd_data;
  logic                  link_back_rev_v;
  logic [link_width-1:0] link_back_rev_data;
  logic                  link_back_ready;
  logic                  edge_fwd_v;         // chain into the tieoff.
  logic [link_width-1:0] edge_fwd_data;
  logic                  edge_rev_v;
  logic [link_width-1:0] edge_rev_data;
  logic                  edge_ready_back;
  logic                  tie_fwd_v;          // tieoff back into the chain.
  logic [link_width-1:0] tie_fwd_data;
  logic                  tie_rev_v;
  logic [link_width-1:0] tie_rev_data;
  logic                  tie_ready;

  ruche_tile_port #(
    .ruche_factor_p (ruche_factor_p),
    .ruche_stage_p  (ruche_stage_p),
    .west_not_east_p(west_not_east_p)
  ) u_tile_port (
    .fwd_v             (fwd_v),
    .fwd_data          (fwd_data),
    .rev_v             (rev_v),
    .rev_data          (rev_data),
    .fwd_ready         (fwd_ready),
    .rev_ret_v         (rev_ret_v),
    .rev_ret_data      (rev_ret_data),
    .link_fwd_v        (link_fwd_v),
    .link_fwd_data     (link_fwd_data),
    .link_rev_v        (link_rev_v),
    .link_rev_data     (link_rev_data),
    .link_ready_back   (link_ready_back),
    .link_back_fwd_v   (link_back_fwd_v),
    .link_back_fwd_data(link_back_fwd_data),
    .link_back_rev_v   (link_back_rev_v),
    .link_back_rev_data(link_back_rev_data),
    .link_back_ready   (link_back_ready)
  );

  ruche_link_chain #(
    .ruche_factor_p (ruche_factor_p),
    .ruche_stage_p  (ruche_stage_p),
    .west_not_east_p(west_not_east_p)
  ) u_chain (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .tile_fwd_v        (link_fwd_v),
    .tile_fwd_data     (link_fwd_data),
    .tile_rev_v        (link_rev_v),
    .tile_rev_data     (link_rev_data),
    .tile_ready_back   (link_ready_back),
    .edge_fwd_v        (edge_fwd_v),
    .edge_fwd_data     (edge_fwd_data),
    .edge_rev_v        (edge_rev_v),
    .edge_rev_data     (edge_rev_data),
    .edge_ready_back   (edge_ready_back),
    .edge_back_fwd_v   (tie_fwd_v),
    .edge_back_fwd_data(tie_fwd_data),
    .edge_back_rev_v   (tie_rev_v),
    .edge_back_rev_data(tie_rev_data),
    .edge_back_ready   (tie_ready),
    .tile_back_fwd_v   (link_back_fwd_v),
    .tile_back_fwd_data(link_back_fwd_data),
    .tile_back_rev_v   (link_back_rev_v),
    .tile_back_rev_data(link_back_rev_data),
    .tile_back_ready   (link_back_ready)
  );

  ruche_edge_tieoff #(
    .ruche_factor_p (ruche_factor_p),
    .ruche_stage_p  (ruche_stage_p),
    .west_not_east_p(west_not_east_p)
  ) u_tieoff (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .edge_fwd_v     (edge_fwd_v),
    .edge_fwd_data  (edge_fwd_data),
    .edge_rev_v     (edge_rev_v),
    .edge_rev_data  (edge_rev_data),
    .edge_ready_back(edge_ready_back),
    .tie_fwd_v      (tie_fwd_v),
    .tie_fwd_data   (tie_fwd_data),
    .tie_rev_v      (tie_rev_v),
    .tie_rev_data   (tie_rev_data),
    .tie_ready      (tie_ready),
    .errant_fwd     (errant_fwd),
    .errant_rev     (errant_rev),
    .errant_count   (errant_count),
    .last_src_x     (last_src_x),
    .last_dest_y    (last_dest_y),
    .last_dest_x    (last_dest_x)
  );

endmodule

`default_nettype wire

// File: verif/tb_ruche_tasks.svh
`ifndef TB_RUCHE_TASKS_SVH
`define TB_RUCHE_TASKS_SVH

// outputs settle and inputs change 1 ns after each rising edge.
task automatic next_cycle();
  @(posedge clk_i);
  #1;
endtask

task automatic drive_lanes(input logic fv, input link_data_t fd,
                           input logic rv, input link_data_t rd);
  fwd_v    = fv;
  fwd_data = fd;
  rev_v    = rv;
  rev_data = rd;
endtask

function automatic int clip_count(input int value);
  return (value > 255) ? 255 : value;  // 8 bit counter stops at the top.
endfunction

task automatic check_bit(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    error_count++;
    $display("Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
  end
endtask

task automatic check_link(input string name, input link_data_t expected,
                          input link_data_t actual);
  if (actual !== expected) begin
    error_count++;
    $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
  end
endtask

task automatic check_x(input string name, input logic [x_cord_width-1:0] expected,
                       input logic [x_cord_width-1:0] actual);
  if (actual !== expected) begin
    error_count++;
    $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
  end
endtask

task automatic check_y(input string name, input logic [y_cord_width-1:0] expected,
                       input logic [y_cord_width-1:0] actual);
  if (actual !== expected) begin
    error_count++;
    $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
  end
endtask

task automatic check_count(input string name, input logic [errant_count_width-1:0] expected,
                           input logic [errant_count_width-1:0] actual);
  if (actual !== expected) begin
    error_count++;
    $display("Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
  end
endtask

task automatic report_test(input string name, input int errors_before);
  if (error_count == errors_before) begin
    pass_tests++;
    $display("test %s: ok", name);
  end else begin
    fail_tests++;
    $display("test %s: %0d failed checks", name, error_count - errors_before);
  end
endtask

task automatic check_quiet(input int count);
  check_bit("errant_fwd", 1'b0, errant_fwd);
  check_bit("errant_rev", 1'b0, errant_rev);
  check_count("errant_count", errant_count_width'(count), errant_count);
  check_bit("rev_ret_v", 1'b0, rev_ret_v);  // tieoff decodes as idle.
  check_link("rev_ret_data", '0, rev_ret_data);  // and as zero data.
  check_bit("fwd_ready", 1'b0, fwd_ready);  // and as not ready.
endtask

task automatic reset_state_test();
  int errors_before;
  errors_before = error_count;
  check_quiet(0);
  check_x("last_src_x", '0, last_src_x);
  check_y("last_dest_y", '0, last_dest_y);
  check_x("last_dest_x", '0, last_dest_x);
  report_test("reset state", errors_before);
endtask

task automatic idle_link_test();
  int errors_before;
  int n;
  errors_before = error_count;
  for (n = 0; n < 50; n++) begin
    next_cycle();
    check_quiet(0);
  end
  report_test("idle link", errors_before);
endtask

// one packet on one lane, the flag must pulse exactly latency_lp cycles later.
task automatic send_packet(input string name, input bit on_fwd, input link_data_t pkt,
                           input logic [x_cord_width-1:0] src_x,
                           input logic [y_cord_width-1:0] dest_y,
                           input logic [x_cord_width-1:0] dest_x);
  int   errors_before;
  int   k;
  logic hit;
  errors_before = error_count;
  drive_lanes(on_fwd, pkt, !on_fwd, pkt);
  for (k = 1; k <= latency_lp + 2; k++) begin
    next_cycle();
    drive_lanes(1'b0, '0, 1'b0, '0);
    hit = (k == latency_lp);
    if (hit) exp_count = clip_count(exp_count + 1);
    check_bit("errant_fwd", on_fwd && hit, errant_fwd);
    check_bit("errant_rev", !on_fwd && hit, errant_rev);
    check_count("errant_count", errant_count_width'(exp_count), errant_count);
  end
  check_x("last_src_x", src_x, last_src_x);
  check_y("last_dest_y", dest_y, last_dest_y);
  check_x("last_dest_x", dest_x, last_dest_x);
  report_test(name, errors_before);
endtask

task automatic fwd_packet_test();
  link_data_t pkt;
  pkt.fwd.addr   = 16'h1234;
  pkt.fwd.data   = 32'hcafe_0001;
  pkt.fwd.src_y  = 3'd2;
  pkt.fwd.src_x  = 4'd5;
  pkt.fwd.dest_y = 3'd6;
  pkt.fwd.dest_x = 4'd11;
  send_packet("fwd packet", 1'b1, pkt, 4'd5, 3'd6, 4'd11);
endtask

task automatic rev_packet_test();
  link_data_t pkt;
  pkt.rev.data   = 32'h5a5a_0f0f;
  pkt.rev.pad    = '0;
  pkt.rev.dest_y = 3'd3;
  pkt.rev.dest_x = 4'd9;
  send_packet("rev packet", 1'b0, pkt, 4'd0, 3'd3, 4'd9);  // a return has no source.
endtask

task automatic random_burst_test();
  int         errors_before;
  int         n;
  int         r;
  logic       fv;
  logic       rv;
  logic       exp_f;
  logic       exp_r;
  logic       fwd_q[$];  // valids still in flight.
  logic       rev_q[$];
  link_data_t pkt_q[$];  // packets still in flight.
  link_data_t pkt;
  link_data_t got;       // packet reaching the edge this cycle.
  errors_before = error_count;
  for (n = 0; n < latency_lp - 1; n++) begin
    fwd_q.push_back(1'b0);  // idle cycles already in the chain.
    rev_q.push_back(1'b0);
    pkt_q.push_back('0);
  end
  for (n = 0; n < burst_cycles_lp + latency_lp; n++) begin
    r              = $random(seed);
    fv             = (n < burst_cycles_lp) ? r[0] : 1'b0;
    rv             = (n < burst_cycles_lp) ? r[1] : 1'b0;
    pkt.fwd        = '0;
    pkt.fwd.data   = $random(seed);
    pkt.fwd.dest_x = r[5:2];
    pkt.fwd.dest_y = r[8:6];
    pkt.fwd.src_x  = r[12:9];  // tells a fwd capture from a rev one.
    drive_lanes(fv, pkt, rv, pkt);
    fwd_q.push_back(fv);
    rev_q.push_back(rv);
    pkt_q.push_back(pkt);
    next_cycle();
    exp_f     = fwd_q.pop_front();
    exp_r     = rev_q.pop_front();
    got       = pkt_q.pop_front();
    exp_count = clip_count(exp_count + exp_f + exp_r);  // both lanes add two.
    check_bit("errant_fwd", exp_f, errant_fwd);
    check_bit("errant_rev", exp_r, errant_rev);
    check_count("errant_count", errant_count_width'(exp_count), errant_count);
    if (exp_f) begin           // fwd wins when both lanes hit.
      check_x("last_src_x", got.fwd.src_x, last_src_x);
      check_y("last_dest_y", got.fwd.dest_y, last_dest_y);
      check_x("last_dest_x", got.fwd.dest_x, last_dest_x);
    end else if (exp_r) begin
      check_x("last_src_x", '0, last_src_x);
      check_y("last_dest_y", got.rev.dest_y, last_dest_y);
      check_x("last_dest_x", got.rev.dest_x, last_dest_x);
    end
  end
  report_test("random burst", errors_before);
endtask

`endif

// File: verif/tb_ruche_x_edge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ruche_x_edge;
  import ruche_pkg::*;

  localparam int factor_lp       = 3;
  localparam int stage_lp        = 2;
  localparam bit west_lp         = 1'b1;
  localparam int latency_lp      = stage_lp + 1;   // drive edge to errant flag.
  localparam int burst_cycles_lp = 300;
  localparam int test_cycles_lp  = 3 + 50 + 2 * (latency_lp + 3) + burst_cycles_lp + latency_lp;
  localparam int watchdog_cycles_lp = test_cycles_lp + 200;  // margin for slack.

  logic                          clk_i;
  logic                          reset_i;
  logic                          fwd_v;
  link_data_t                    fwd_data;
  logic                          rev_v;
  link_data_t                    rev_data;
  logic                          fwd_ready;
  logic                          rev_ret_v;
  link_data_t                    rev_ret_data;
  logic                          errant_fwd;
  logic                          errant_rev;
  logic [errant_count_width-1:0] errant_count;
  logic [x_cord_width-1:0]       last_src_x;
  logic [y_cord_width-1:0]       last_dest_y;
  logic [x_cord_width-1:0]       last_dest_x;

  int     error_count;   // failed checks so far.
  int     pass_tests;
  int     fail_tests;
  int     exp_count;     // model of the errant counter.
  integer seed;

  ruche_x_edge_top #(
    .ruche_factor_p (factor_lp),
    .ruche_stage_p  (stage_lp),
    .west_not_east_p(west_lp)
  ) uut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .fwd_v       (fwd_v),
    .fwd_data    (fwd_data),
    .rev_v       (rev_v),
    .rev_data    (rev_data),
    .fwd_ready   (fwd_ready),
    .rev_ret_v   (rev_ret_v),
    .rev_ret_data(rev_ret_data),
    .errant_fwd  (errant_fwd),
    .errant_rev  (errant_rev),
    .errant_count(errant_count),
    .last_src_x  (last_src_x),
    .last_dest_y (last_dest_y),
    .last_dest_x (last_dest_x)
  );

  always #5 clk_i = ~clk_i;  // 10 ns period.

  initial begin : watchdog
    #(watchdog_cycles_lp * 10);
    $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles_lp);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    clk_i       = 1'b0;
    reset_i     = 1'b0;  // held through the first three edges.
    fwd_v       = 1'b0;
    fwd_data    = '0;
    rev_v       = 1'b0;
    rev_data    = '0;
    error_count = 0;
    pass_tests  = 0;
    fail_tests  = 0;
    exp_count   = 0;
    seed        = 32'he290;
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b1;
    reset_state_test();
    idle_link_test();
    fwd_packet_test();
    rev_packet_test();
    random_burst_test();
    $display("summary: %0d tests passed, %0d tests failed, %0d failed checks",
             pass_tests, fail_tests, error_count);
    if (fail_tests == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  `include "tb_ruche_tasks.svh"

endmodule

`default_nettype wire

// File: build.f
+incdir+verif
hdl/ruche_pkg.sv
hdl/ruche_link_stage.sv
hdl/ruche_link_chain.sv
hdl/ruche_tile_port.sv
hdl/ruche_edge_tieoff.sv
hdl/ruche_x_edge_top.sv
verif/tb_ruche_x_edge.sv
